// ==== Makefile ====
# Verilator build and run for the flit buffer testbench

VERILATOR ?= verilator
TOP       ?= flit_buffer_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
# keep running after an assertion so the testbench can report it
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

.DEFAULT_GOAL := help

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/flit_buffer.sv ====
module flit_buffer
    import flit_buffer_pkg::*;
#(
    parameter int VCS   = NUM_VC,
    parameter int DEPTH = VC_DEPTH
) (
    input  logic           clk,
    input  logic           reset,
    // write side, vc one-hot while wr_en is high
    input  logic           wr_en,
    input  logic [VCS-1:0] wr_vc,
    input  flit_t          din,
    // read side, vc one-hot while rd_en is high
    input  logic           rd_en,
    input  logic [VCS-1:0] rd_vc,
    // flit of the last accepted read
    output flit_t          dout,
    output logic [VCS-1:0] vc_not_empty
);

    // address split, vc index on top of the slot pointer
    localparam int PTR_WIDTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int IDX_WIDTH  = (VCS > 1) ? $clog2(VCS) : 1;
    localparam int ADDR_WIDTH = IDX_WIDTH + PTR_WIDTH;

    // per-vc strobes
    logic [VCS-1:0] wr;
    logic [VCS-1:0] rd;

    // per-vc grants
    logic [VCS-1:0] wr_accept;
    logic [VCS-1:0] rd_accept;

    // all pointers, packed for the selectors
    logic [VCS-1:0][PTR_WIDTH-1:0] wr_ptrs;
    logic [VCS-1:0][PTR_WIDTH-1:0] rd_ptrs;

    // RAM side
    logic [ADDR_WIDTH-1:0] ram_wr_addr;
    logic [ADDR_WIDTH-1:0] ram_rd_addr;
    logic                  ram_wr_en;
    logic                  ram_rd_en;
    ram_entry_t            ram_din;
    ram_entry_t            ram_dout;

    // vc of the read in flight
    logic [VCS-1:0] rd_vc_q;

    // spread the strobes over the vcs
    assign wr = wr_en ? wr_vc : '0;
    assign rd = rd_en ? rd_vc : '0;

    // one controller per vc
    for (genvar i = 0; i < VCS; i++) begin : g_vc
        vc_queue_ctrl #(
            .DEPTH     (DEPTH),
            .PTR_WIDTH (PTR_WIDTH)
        ) u_ctrl (
            .clk       (clk),
            .reset     (reset),
            .wr        (wr[i]),
            .rd        (rd[i]),
            .wr_ptr    (wr_ptrs[i]),
            .rd_ptr    (rd_ptrs[i]),
            .not_empty (vc_not_empty[i]),
            .wr_accept (wr_accept[i]),
            .rd_accept (rd_accept[i])
        );
    end

    // only granted strobes reach the RAM
    // a write to a full vc is dropped here
    assign ram_wr_en = |wr_accept;
    assign ram_rd_en = |rd_accept;

    // vc field not stored
    assign ram_din = '{hdr: din.hdr, tail: din.tail, payload: din.payload};

    // write slot
    vc_addr_select #(
        .VCS       (VCS),
        .PTR_WIDTH (PTR_WIDTH)
    ) u_wr_sel (
        .vc_sel (wr_vc),
        .ptrs   (wr_ptrs),
        .addr   (ram_wr_addr)
    );

    // read slot
    vc_addr_select #(
        .VCS       (VCS),
        .PTR_WIDTH (PTR_WIDTH)
    ) u_rd_sel (
        .vc_sel (rd_vc),
        .ptrs   (rd_ptrs),
        .addr   (ram_rd_addr)
    );

    // shared storage
    flit_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (ram_wr_en),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_din),
        .rd_en   (ram_rd_en),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_dout)
    );

    // loads with the RAM read register, so the two stay aligned
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_vc_q <= '0;
        end else if (ram_rd_en) begin
            rd_vc_q <= rd_vc;
        end
    end

    // rebuild the port flit
    assign dout = '{hdr: ram_dout.hdr, tail: ram_dout.tail, vc: rd_vc_q,
                    payload: ram_dout.payload};

endmodule

// ==== hw/flit_buffer_pkg.sv ====
package flit_buffer_pkg;

    // number of virtual channels on the port
    localparam int NUM_VC = 2;

    // flits per virtual channel, power of two
    localparam int VC_DEPTH = 4;

    // flit payload bits
    localparam int PAYLOAD_W = 32;

    // per-VC pointer width
    localparam int PTR_W = (VC_DEPTH > 1) ? $clog2(VC_DEPTH) : 1;

    // binary VC index width
    // kept at one bit for a single VC so the RAM address stays well formed
    localparam int VCID_W = (NUM_VC > 1) ? $clog2(NUM_VC) : 1;

    // flit as seen on the router port
    // msb first: header, tail, one-hot vc, payload
    typedef struct packed {
        // first flit of a packet
        logic                 hdr;
        // last flit of a packet
        logic                 tail;
        // one-hot virtual channel
        logic [NUM_VC-1:0]    vc;
        // flit data
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // flit as stored in the shared RAM
    // vc field dropped, the slot address already encodes it
    typedef struct packed {
        // first flit of a packet
        logic                 hdr;
        // last flit of a packet
        logic                 tail;
        // flit data
        logic [PAYLOAD_W-1:0] payload;
    } ram_entry_t;

endpackage

// ==== hw/flit_ram.sv ====
module flit_ram
    import flit_buffer_pkg::*;
#(
    // index bits plus pointer bits
    parameter int ADDR_WIDTH = VCID_W + PTR_W
) (
    input  logic                  clk,
    input  logic                  reset,
    // write port
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  ram_entry_t            wr_data,
    // read port, one cycle latency
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output ram_entry_t            rd_data
);

    // one slot per address, all vcs together
    ram_entry_t mem [2**ADDR_WIDTH];

    // storage write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read
    // holds its value until the next accepted read
    // a same-edge write never hits the read slot, the guards keep them apart
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hw/vc_addr_select.sv ====
module vc_addr_select
    import flit_buffer_pkg::*;
#(
    parameter int VCS       = NUM_VC,
    parameter int PTR_WIDTH = PTR_W,
    // binary index width, one bit minimum
    localparam int IDX_W    = (VCS > 1) ? $clog2(VCS) : 1
) (
    // one-hot vc code
    input  logic [VCS-1:0]                vc_sel,
    // one pointer per vc, vc 0 in the low slot
    input  logic [VCS-1:0][PTR_WIDTH-1:0] ptrs,
    // shared RAM address, index above pointer
    output logic [IDX_W+PTR_WIDTH-1:0]    addr
);

    // binary vc index
    logic [IDX_W-1:0]     vc_idx;

    // pointer of the selected vc
    logic [PTR_WIDTH-1:0] vc_ptr;

    // one-hot to binary
    // OR of the positions of the set bits, exact for a one-hot code
    always_comb begin
        vc_idx = '0;
        for (int i = 0; i < VCS; i++) begin
            if (vc_sel[i]) begin
                vc_idx = vc_idx | IDX_W'(i);
            end
        end
    end

    // masked OR mux over the pointers
    // each pointer ANDed with its select bit
    always_comb begin
        vc_ptr = '0;
        for (int i = 0; i < VCS; i++) begin
            vc_ptr = vc_ptr | (ptrs[i] & {PTR_WIDTH{vc_sel[i]}});
        end
    end

    // each vc owns a contiguous slice of the RAM
    assign addr = {vc_idx, vc_ptr};

endmodule

// ==== hw/vc_queue_ctrl.sv ====
module vc_queue_ctrl
    import flit_buffer_pkg::*;
#(
    parameter int DEPTH     = VC_DEPTH,
    parameter int PTR_WIDTH = PTR_W
) (
    input  logic                 clk,
    input  logic                 reset,
    // write strobe for this vc
    input  logic                 wr,
    // read strobe for this vc
    input  logic                 rd,
    output logic [PTR_WIDTH-1:0] wr_ptr,
    output logic [PTR_WIDTH-1:0] rd_ptr,
    output logic                 not_empty,
    // write granted this cycle
    output logic                 wr_accept,
    // read granted this cycle
    output logic                 rd_accept
);

    // depth counter is one bit wider so full is representable
    localparam logic [PTR_WIDTH:0]   DEPTH_MAX = (PTR_WIDTH + 1)'(DEPTH);

    // last slot of the circular buffer
    localparam logic [PTR_WIDTH-1:0] PTR_LAST  = PTR_WIDTH'(DEPTH - 1);

    // flits currently held
    logic [PTR_WIDTH:0] depth;

    // guards look at the depth before this cycle's strobes
    // so a write to a full queue is refused even with a read alongside
    assign wr_accept = wr && (depth < DEPTH_MAX);
    assign rd_accept = rd && (depth != '0);

    // level straight from the counter
    assign not_empty = (depth != '0);

    // write pointer, wraps at the end of the slice
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            if (wr_ptr == PTR_LAST) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // read pointer, same wrap rule
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            if (rd_ptr == PTR_LAST) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // depth follows the granted strobes only
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            depth <= '0;
        end else begin
            case ({wr_accept, rd_accept})
                // write only
                2'b10: begin
                    depth <= depth + 1'b1;
                end
                // read only
                2'b01: begin
                    depth <= depth - 1'b1;
                end
                // both or neither, no change
                default: begin
                    depth <= depth;
                end
            endcase
        end
    end

endmodule

// ==== project.f ====
hw/flit_buffer_pkg.sv
hw/vc_queue_ctrl.sv
hw/vc_addr_select.sv
hw/flit_ram.sv
hw/flit_buffer.sv
verif/flit_buffer_checker.sv
verif/flit_buffer_tb.sv

// ==== verif/flit_buffer_checker.sv ====
module flit_buffer_checker
    import flit_buffer_pkg::*;
#(
    parameter int VCS   = NUM_VC,
    parameter int DEPTH = VC_DEPTH
) (
    input logic           clk,
    input logic           reset,
    input logic           wr_en,
    input logic [VCS-1:0] wr_vc,
    input flit_t          din,
    input logic           rd_en,
    input logic [VCS-1:0] rd_vc,
    input flit_t          dout,
    input logic [VCS-1:0] vc_not_empty
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // shadow queues, one per vc
    flit_t                fifo [VCS][DEPTH];
    logic [PTR_WIDTH-1:0] head [VCS];
    logic [PTR_WIDTH:0]   cnt  [VCS];

    // grants as the port rules give them
    logic [VCS-1:0] wr_ok;
    logic [VCS-1:0] rd_ok;
    logic [VCS-1:0] exp_not_empty;

    // flit the last accepted read should show
    flit_t exp_dout;

    // one sticky flag per assertion
    logic err_reset    = 1'b0;
    logic err_select   = 1'b0;
    logic err_data     = 1'b0;
    logic err_hold     = 1'b0;
    logic err_level    = 1'b0;
    logic err_same_cyc = 1'b0;
    logic check_failed;

    assign check_failed = err_reset | err_select | err_data | err_hold | err_level |
                          err_same_cyc;

    // guards use the count before this cycle's strobes
    always_comb begin
        for (int v = 0; v < VCS; v++) begin
            wr_ok[v]         = wr_en && wr_vc[v] && (cnt[v] < (PTR_WIDTH + 1)'(DEPTH));
            rd_ok[v]         = rd_en && rd_vc[v] && (cnt[v] != '0);
            exp_not_empty[v] = (cnt[v] != '0);
        end
    end

    // reference model of the queues
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < VCS; v++) begin
                head[v] <= '0;
                cnt[v]  <= '0;
            end
            exp_dout <= '0;
        end else begin
            for (int v = 0; v < VCS; v++) begin
                // append behind the oldest flit
                if (wr_ok[v]) begin
                    fifo[v][PTR_WIDTH'(head[v] + cnt[v][PTR_WIDTH-1:0])] <= din;
                end
                // pop the oldest, vc field taken from the read select
                if (rd_ok[v]) begin
                    exp_dout <= '{hdr: fifo[v][head[v]].hdr,
                                  tail: fifo[v][head[v]].tail,
                                  vc: rd_vc,
                                  payload: fifo[v][head[v]].payload};
                    head[v]  <= head[v] + PTR_WIDTH'(1);
                end
                cnt[v] <= cnt[v] + (PTR_WIDTH + 1)'(wr_ok[v]) - (PTR_WIDTH + 1)'(rd_ok[v]);
            end
        end
    end

    // outputs cleared once reset has seen an edge
    a_reset_state: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (vc_not_empty == '0 && dout == '0))
        else begin
            err_reset = 1'b1;
            $error("outputs not cleared during reset");
        end

    // select codes one-hot under their strobe
    a_select_onehot: assert property (@(posedge clk) disable iff (reset)
        (!wr_en || $onehot(wr_vc)) && (!rd_en || $onehot(rd_vc)))
        else begin
            err_select = 1'b1;
            $error("vc select not one-hot while its strobe is high");
        end

    // read data one cycle after the grant
    a_read_data: assert property (@(posedge clk) disable iff (reset)
        (|rd_ok) |=> (dout == exp_dout))
        else begin
            err_data = 1'b1;
            $error("dout differs from the oldest flit of the read vc");
        end

    // no grant, no change on dout
    a_dout_hold: assert property (@(posedge clk) disable iff (reset)
        !(|rd_ok) |=> $stable(dout))
        else begin
            err_hold = 1'b1;
            $error("dout changed without an accepted read");
        end

    // level matches the shadow count, covers both guards
    a_not_empty: assert property (@(posedge clk) disable iff (reset)
        vc_not_empty == exp_not_empty)
        else begin
            err_level = 1'b1;
            $error("vc_not_empty differs from the shadow queues");
        end

    // write and read of one vc leave its level alone
    a_same_cycle: assert property (@(posedge clk) disable iff (reset)
        (|(wr_ok & rd_ok)) |=> $stable(vc_not_empty))
        else begin
            err_same_cyc = 1'b1;
            $error("same-cycle write and read changed the level");
        end

endmodule

bind flit_buffer flit_buffer_checker #(
    .VCS   (VCS),
    .DEPTH (DEPTH)
) u_checker (
    .clk          (clk),
    .reset        (reset),
    .wr_en        (wr_en),
    .wr_vc        (wr_vc),
    .din          (din),
    .rd_en        (rd_en),
    .rd_vc        (rd_vc),
    .dout         (dout),
    .vc_not_empty (vc_not_empty)
);

// ==== verif/flit_buffer_tb.sv ====
module flit_buffer_tb
    import flit_buffer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int RANDOM_CYCLES = 400;
    localparam int DRAIN_CYCLES  = 2 * VC_DEPTH;
    // every phase plus slack, doubled for margin
    localparam int TOTAL_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + 3 * NUM_VC * DRAIN_CYCLES +
                                   6 * (VC_DEPTH + 2) + 40;
    localparam int WATCHDOG_NS   = 2 * TOTAL_CYCLES * CLK_PERIOD;

    logic              clk;
    logic              reset;
    logic              wr_en;
    logic [NUM_VC-1:0] wr_vc;
    flit_t             din;
    logic              rd_en;
    logic [NUM_VC-1:0] rd_vc;
    flit_t             dout;
    logic [NUM_VC-1:0] vc_not_empty;

    int seed = 32'hc045;

    flit_buffer #(
        .VCS   (NUM_VC),
        .DEPTH (VC_DEPTH)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_vc        (wr_vc),
        .din          (din),
        .rd_en        (rd_en),
        .rd_vc        (rd_vc),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // vc index to one-hot
    function automatic logic [NUM_VC-1:0] vc_code(input int idx);
        vc_code = NUM_VC'(1) << idx;
    endfunction

    // random header, tail and payload, vc field set to the target
    function automatic flit_t random_flit(input int idx);
        logic [31:0] r;
        flit_t       f;
        r         = $random(seed);
        f.hdr     = r[0];
        f.tail    = r[1];
        f.vc      = vc_code(idx);
        f.payload = $random(seed);
        return f;
    endfunction

    function automatic string failed_check_name();
        if (uut.u_checker.err_reset)    return "outputs not cleared during reset";
        if (uut.u_checker.err_select)   return "vc select code not one-hot";
        if (uut.u_checker.err_data)     return "wrong flit on dout after a read";
        if (uut.u_checker.err_hold)     return "dout changed without a read";
        if (uut.u_checker.err_level)    return "vc_not_empty does not match";
        if (uut.u_checker.err_same_cyc) return "same-cycle write and read changed level";
        return "assertion failed in the bound checker";
    endfunction

    // one clock of stimulus, all inputs at once
    task automatic drive_cycle(input logic w, input int wvc, input flit_t f,
                               input logic r, input int rvc);
        @(posedge clk);
        wr_en <= w;
        wr_vc <= vc_code(wvc);
        din   <= f;
        rd_en <= r;
        rd_vc <= vc_code(rvc);
    endtask

    task automatic write_flit(input int vc);
        drive_cycle(1'b1, vc, random_flit(vc), 1'b0, 0);
    endtask

    task automatic read_flit(input int vc);
        drive_cycle(1'b0, 0, '0, 1'b1, vc);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 0, '0, 1'b0, 0);
    endtask

    // extra reads on an empty vc are refused
    task automatic drain_vc(input int vc);
        repeat (DRAIN_CYCLES) read_flit(vc);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic        w;
        logic        rd;
        int          wvc;
        int          rvc;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_vc = '0;
        din   = '0;
        rd_en = 1'b0;
        rd_vc = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(2);

        // interleaved traffic, write heavy first half then read heavy
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r   = $random(seed);
            wvc = int'(r[7:0]) % NUM_VC;
            rvc = int'(r[15:8]) % NUM_VC;
            if (i < RANDOM_CYCLES / 2) begin
                w  = r[16] | r[17];
                rd = r[18] & r[19];
            end else begin
                w  = r[16] & r[17];
                rd = r[18] | r[19];
            end
            drive_cycle(w, wvc, random_flit(wvc), rd, rvc);
        end
        for (int v = 0; v < NUM_VC; v++) begin
            drain_vc(v);
        end

        // full guard on vc 0, two writes past the limit
        repeat (VC_DEPTH + 2) write_flit(0);
        // write refused even with a read alongside
        drive_cycle(1'b1, 0, random_flit(0), 1'b1, 0);
        repeat (VC_DEPTH) read_flit(0);
        idle_cycles(2);

        // empty guard on vc 1
        read_flit(1);
        read_flit(1);
        idle_cycles(1);
        write_flit(1);
        read_flit(1);
        idle_cycles(2);

        // same-cycle write and read on vc 1
        write_flit(1);
        write_flit(1);
        repeat (6) drive_cycle(1'b1, 1, random_flit(1), 1'b1, 1);
        repeat (3) read_flit(1);
        idle_cycles(4);

        if (uut.u_checker.check_failed) begin
            $display("[FAIL] %0d ns: %s", $time, failed_check_name());
            $display("SOME TESTS FAILED");
            $fatal(1, "checks failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    // stop at the first failed assertion
    initial begin : failure_hook
        wait (uut.u_checker.check_failed === 1'b1);
        $display("[FAIL] %0d ns: %s", $time, failed_check_name());
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failed check");
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
